// File: logic/dsp_pkg.sv
package dsp_pkg;

	localparam int CHANNELS   = 4;
	localparam int CODE_W     = 8;
	localparam int EST_W      = 10;
	localparam int WEIGHT_W   = 6;
	localparam int FFE_TAPS   = 3;
	localparam int SHIFT_W    = 3;
	localparam int HIST_DEPTH = 3;

	// Accumulator holds three full products without overflow.
	localparam int ACC_W = CODE_W + WEIGHT_W + 2;

	// Checker error covers code minus a prediction of up to twice a tap.
	localparam int ERR_W = CODE_W + 3;

	// Saturation limit, symmetric around zero.
	localparam int EST_MAX = 2 ** (EST_W - 1) - 1;

	// Edges from frame entry to each output.
	localparam int EST_LATENCY   = 2;
	localparam int CHECK_LATENCY = 4;

	typedef logic signed [CODE_W-1:0]   code_t;
	typedef logic signed [EST_W-1:0]    est_t;
	typedef logic signed [WEIGHT_W-1:0] weight_t;
	typedef logic        [SHIFT_W-1:0]  shift_t;
	typedef logic signed [CODE_W-1:0]   chan_est_t;
	typedef logic signed [ACC_W-1:0]    acc_t;
	typedef logic signed [ERR_W-1:0]    err_t;

	typedef code_t   [CHANNELS-1:0]   code_frame_t;
	typedef est_t    [CHANNELS-1:0]   est_frame_t;
	typedef logic    [CHANNELS-1:0]   bit_frame_t;
	typedef code_frame_t [HIST_DEPTH-1:0] code_hist_t;
	typedef weight_t [FFE_TAPS-1:0]   weight_vec_t;

	typedef struct packed {
		weight_vec_t ffe_weights; // Tap j weights the symbol j positions back.
		shift_t      ffe_shift;
		est_t        slice_thresh;
		chan_est_t   h0;          // Cursor.
		chan_est_t   h1;          // First post-cursor.
	} dsp_cfg_t;

endpackage : dsp_pkg

// File: logic/code_history.sv
`timescale 1ns/1ns

module code_history import dsp_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  code_frame_t frame_i,
	output code_hist_t  history_o
);

	// Entry 0 holds the newest frame, older frames move up by one each clock.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			history_o <= '0;
		end else begin
			history_o <= {history_o[HIST_DEPTH-2:0], frame_i};
		end
	end

endmodule : code_history

// File: logic/ffe_filter.sv
`timescale 1ns/1ns

module ffe_filter import dsp_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  code_frame_t cur_frame_i,
	input  code_frame_t prev_frame_i,
	input  weight_vec_t weights_i,
	input  shift_t      shift_i,
	output est_frame_t  est_o
);

	code_t [2*CHANNELS-1:0] window; // Previous frame low, current frame high.
	est_frame_t             est_d;

	assign window = {cur_frame_i, prev_frame_i};

	always_comb begin
		acc_t sum;
		acc_t prod;
		acc_t shifted;
		for (int i = 0; i < CHANNELS; i++) begin
			sum = '0;
			for (int j = 0; j < FFE_TAPS; j++) begin
				// Symbol j positions earlier than channel i of the current frame.
				prod = acc_t'(window[CHANNELS+i-j]) * acc_t'(weights_i[j]);
				sum  = sum + prod;
			end
			shifted = sum >>> shift_i;
			if (shifted > acc_t'(EST_MAX)) begin
				est_d[i] = est_t'(EST_MAX);
			end else if (shifted < -acc_t'(EST_MAX)) begin
				est_d[i] = -est_t'(EST_MAX); // Symmetric clamp.
			end else begin
				est_d[i] = est_t'(shifted);
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			est_o <= '0;
		end else begin
			est_o <= est_d;
		end
	end

endmodule : ffe_filter

// File: logic/bit_slicer.sv
`timescale 1ns/1ns

module bit_slicer import dsp_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  est_frame_t est_i,
	input  est_t       thresh_i,
	output bit_frame_t bits_o,
	output logic       prev_bit_o
);

	bit_frame_t bits_d;

	always_comb begin
		for (int i = 0; i < CHANNELS; i++) begin
			bits_d[i] = (est_i[i] > thresh_i); // Strictly above the threshold.
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bits_o     <= '0;
			prev_bit_o <= 1'b0;
		end else begin
			bits_o     <= bits_d;
			prev_bit_o <= bits_o[CHANNELS-1]; // Last symbol of the prior frame.
		end
	end

endmodule : bit_slicer

// File: logic/mlsd_checker.sv
`timescale 1ns/1ns

module mlsd_checker import dsp_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  code_frame_t codes_i,
	input  bit_frame_t bits_i,
	input  logic       prev_bit_i,
	input  chan_est_t  h0_i,
	input  chan_est_t  h1_i,
	output bit_frame_t checked_o
);

	logic [CHANNELS:0] seq;     // Sliced symbols with the one before channel 0.
	bit_frame_t        checked_d;

	// Absolute error between a received code and the two-tap prediction.
	function automatic err_t abs_err(
		input code_t     code,
		input chan_est_t h0,
		input chan_est_t h1,
		input logic      b,
		input logic      b_prev
	);
		err_t pred;
		err_t diff;
		pred = (b ? err_t'(h0) : -err_t'(h0)) + (b_prev ? err_t'(h1) : -err_t'(h1));
		diff = err_t'(code) - pred;
		return (diff < 0) ? -diff : diff;
	endfunction

	assign seq = {bits_i, prev_bit_i};

	always_comb begin
		err_t err_keep;
		err_t err_flip;
		for (int i = 0; i < CHANNELS; i++) begin
			err_keep = abs_err(codes_i[i], h0_i, h1_i, seq[i+1], seq[i]);
			err_flip = abs_err(codes_i[i], h0_i, h1_i, ~seq[i+1], seq[i]);
			// A tie keeps the sliced bit.
			checked_d[i] = (err_flip < err_keep) ? ~seq[i+1] : seq[i+1];
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			checked_o <= '0;
		end else begin
			checked_o <= checked_d;
		end
	end

endmodule : mlsd_checker

// File: logic/dsp_backend.sv
`timescale 1ns/1ns

module dsp_backend import dsp_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  code_frame_t codes_i,
	input  dsp_cfg_t    cfg_i,
	output est_frame_t  estimated_bits_o,
	output bit_frame_t  checked_bits_o
);

	code_hist_t history;
	bit_frame_t sliced_bits;
	logic       sliced_prev_bit;

	code_history code_history_i (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.frame_i   (codes_i),
		.history_o (history)
	);

	// Equalizer spans the newest frame and the one before it.
	ffe_filter ffe_filter_i (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.cur_frame_i  (history[0]),
		.prev_frame_i (history[1]),
		.weights_i    (cfg_i.ffe_weights),
		.shift_i      (cfg_i.ffe_shift),
		.est_o        (estimated_bits_o)
	);

	bit_slicer bit_slicer_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.est_i      (estimated_bits_o),
		.thresh_i   (cfg_i.slice_thresh),
		.bits_o     (sliced_bits),
		.prev_bit_o (sliced_prev_bit)
	);

	// Entry 2 is the frame whose sliced bits arrive in the same cycle.
	mlsd_checker mlsd_checker_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.codes_i    (history[2]),
		.bits_i     (sliced_bits),
		.prev_bit_i (sliced_prev_bit),
		.h0_i       (cfg_i.h0),
		.h1_i       (cfg_i.h1),
		.checked_o  (checked_bits_o)
	);

endmodule : dsp_backend

// File: testbench/dsp_backend_properties.sv
`timescale 1ns/1ns

module dsp_backend_properties import dsp_pkg::*; (
	input logic       clk_i,
	input logic       rst_n_i,
	input dsp_cfg_t   cfg_i,
	input bit_frame_t sliced_bits_i,
	input est_frame_t estimated_bits_i,
	input bit_frame_t checked_bits_i
);

	// Both outputs sit at zero while reset is held.
	reset_zero: assert property (@(posedge clk_i)
		!rst_n_i |-> (estimated_bits_i == '0 && checked_bits_i == '0))
		else $error("outputs not zero during reset");

	// With no cursor both hypotheses predict the same code.
	flip_needs_cursor: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(checked_bits_i != $past(sliced_bits_i)) |-> (cfg_i.h0 != '0))
		else $error("checked bits flipped with a zero cursor");

	for (genvar i = 0; i < CHANNELS; i++) begin : g_sat
		no_min_est: assert property (@(posedge clk_i)
			estimated_bits_i[i] != {1'b1, {(EST_W-1){1'b0}}})
			else $error("estimate %0d reached the most negative value", i);
	end

endmodule : dsp_backend_properties

bind dsp_backend dsp_backend_properties props_i (
	.clk_i            (clk_i),
	.rst_n_i          (rst_n_i),
	.cfg_i            (cfg_i),
	.sliced_bits_i    (sliced_bits),
	.estimated_bits_i (estimated_bits_o),
	.checked_bits_i   (checked_bits_o)
);

// File: testbench/dsp_backend_tb.sv
`timescale 1ns/1ns

module dsp_backend_tb import dsp_pkg::*; ();

	typedef enum {MODE_RAMP, MODE_EXTREME, MODE_RANDOM, MODE_RANDOM_TIE} code_mode_e;
	typedef enum {KIND_RESET, KIND_EST, KIND_SAT, KIND_BITS, KIND_MLSD} check_kind_e;

	typedef struct {
		string       name;
		dsp_cfg_t    cfg;
		int          frames;
		code_mode_e  mode;
		check_kind_e kind;
	} test_row_t;

	logic        clk_i;
	logic        rst_n_i;
	code_frame_t codes_i;
	dsp_cfg_t    cfg_i;
	est_frame_t  estimated_bits_o;
	bit_frame_t  checked_bits_o;

	test_row_t  tests[6];
	est_frame_t est_q[$];
	bit_frame_t bit_q[$];
	int         sym_hist[$]; // Model symbol history with the newest at the back.
	logic       last_bit;    // Model sliced bit of the previous symbol.
	int         flip_count;
	int         tie_count;
	int         sat_hi_count;
	int         sat_lo_count;
	int         err_count;
	int         check_count;

	dsp_backend uut (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.codes_i          (codes_i),
		.cfg_i            (cfg_i),
		.estimated_bits_o (estimated_bits_o),
		.checked_bits_o   (checked_bits_o)
	);

	initial clk_i = 1'b0;
	always #10 clk_i = ~clk_i;

	function automatic dsp_cfg_t make_cfg(
		input int w0,
		input int w1,
		input int w2,
		input int sh,
		input int th,
		input int h0,
		input int h1
	);
		dsp_cfg_t c;
		c.ffe_weights[0] = weight_t'(w0);
		c.ffe_weights[1] = weight_t'(w1);
		c.ffe_weights[2] = weight_t'(w2);
		c.ffe_shift      = shift_t'(sh);
		c.slice_thresh   = est_t'(th);
		c.h0             = chan_est_t'(h0);
		c.h1             = chan_est_t'(h1);
		return c;
	endfunction

	function automatic code_frame_t gen_frame(input code_mode_e mode, input int n,
		input dsp_cfg_t cfg);
		code_frame_t f;
		for (int i = 0; i < CHANNELS; i++) begin
			case (mode)
				MODE_RAMP:    f[i] = code_t'((n * CHANNELS + i) * 29 - 100);
				MODE_EXTREME: f[i] = (n % 2 == 0) ? code_t'(120) : code_t'(-120); // Sign flips per frame.
				// A flat frame at minus h1 ties on channel 3 when the taps sum to zero.
				MODE_RANDOM_TIE: f[i] = (n % 4 == 3) ? code_t'(-int'(cfg.h1))
					: code_t'($urandom);
				default:      f[i] = code_t'($urandom);
			endcase
		end
		return f;
	endfunction

	task automatic model_reset(input dsp_cfg_t cfg);
		sym_hist.delete();
		sym_hist.push_back(0);
		sym_hist.push_back(0);
		last_bit     = (0 > int'(cfg.slice_thresh)); // Zero frames flow ahead of the first one.
		flip_count   = 0;
		tie_count    = 0;
		sat_hi_count = 0;
		sat_lo_count = 0;
	endtask

	// Expected estimates and checked bits of one frame go into the compare queues.
	task automatic model_frame(input code_frame_t f, input dsp_cfg_t cfg);
		est_frame_t e;
		bit_frame_t chk;
		int acc;
		int c;
		int pred_keep;
		int pred_flip;
		int err_keep;
		int err_flip;
		logic b;
		for (int i = 0; i < CHANNELS; i++) begin
			c = int'(f[i]);
			sym_hist.push_back(c);
			acc = 0;
			for (int j = 0; j < FFE_TAPS; j++) begin
				acc += int'(cfg.ffe_weights[j]) * sym_hist[sym_hist.size() - 1 - j];
			end
			void'(sym_hist.pop_front());
			acc = acc >>> cfg.ffe_shift;
			if (acc > EST_MAX) begin
				acc = EST_MAX;
				sat_hi_count++;
			end else if (acc < -EST_MAX) begin
				acc = -EST_MAX;
				sat_lo_count++;
			end
			e[i] = est_t'(acc);
			b = (acc > int'(cfg.slice_thresh));
			pred_keep = (b ? int'(cfg.h0) : -int'(cfg.h0))
				+ (last_bit ? int'(cfg.h1) : -int'(cfg.h1));
			pred_flip = (b ? -int'(cfg.h0) : int'(cfg.h0))
				+ (last_bit ? int'(cfg.h1) : -int'(cfg.h1));
			err_keep = (c - pred_keep < 0) ? pred_keep - c : c - pred_keep;
			err_flip = (c - pred_flip < 0) ? pred_flip - c : c - pred_flip;
			if (err_flip < err_keep) begin
				chk[i] = ~b;
				flip_count++;
			end else begin
				chk[i] = b; // Ties keep the sliced bit.
				if (err_flip == err_keep) begin
					tie_count++;
				end
			end
			last_bit = b;
		end
		est_q.push_back(e);
		bit_q.push_back(chk);
	endtask

	task automatic check_est(input string name, input int frame, input est_frame_t exp,
		input est_frame_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("[FAIL] %s estimate frame %0d: expected %h, actual %h",
				name, frame, exp, act);
		end
	endtask

	task automatic check_bits(input string name, input int frame, input bit_frame_t exp,
		input bit_frame_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("[FAIL] %s checked bits frame %0d: expected %b, actual %b",
				name, frame, exp, act);
		end
	endtask

	task automatic run_test(input test_row_t row);
		code_frame_t fr;
		int errs_before;
		errs_before = err_count;
		est_q.delete();
		bit_q.delete();
		model_reset(row.cfg);
		@(posedge clk_i);
		rst_n_i <= 1'b0;
		codes_i <= '0;
		cfg_i   <= row.cfg;
		repeat (2) begin
			@(negedge clk_i);
			check_est(row.name, -1, '0, estimated_bits_o);
			check_bits(row.name, -1, '0, checked_bits_o);
			@(posedge clk_i);
		end
		rst_n_i <= 1'b1;
		for (int cyc = 0; cyc < row.frames + CHECK_LATENCY; cyc++) begin
			@(posedge clk_i);
			if (cyc < row.frames) begin
				fr = gen_frame(row.mode, cyc, row.cfg);
				codes_i <= fr;
				model_frame(fr, row.cfg);
			end else begin
				codes_i <= '0;
			end
			@(negedge clk_i);
			if (cyc >= EST_LATENCY && cyc < row.frames + EST_LATENCY) begin
				check_est(row.name, cyc - EST_LATENCY, est_q.pop_front(), estimated_bits_o);
			end else if (row.kind == KIND_RESET && cyc < EST_LATENCY) begin
				check_est(row.name, -1, '0, estimated_bits_o); // Nothing has arrived yet.
			end
			if (cyc >= CHECK_LATENCY) begin
				check_bits(row.name, cyc - CHECK_LATENCY, bit_q.pop_front(), checked_bits_o);
			end else if (row.kind == KIND_RESET) begin
				check_bits(row.name, -1, '0, checked_bits_o);
			end
		end
		if (row.kind == KIND_SAT && (sat_hi_count == 0 || sat_lo_count == 0)) begin
			err_count++;
			$display("%s: stimulus did not reach both saturation limits", row.name);
		end
		if (row.kind == KIND_BITS && flip_count != 0) begin
			err_count++;
			$display("%s: model flipped bits although the post-cursor is zero", row.name);
		end
		if (row.kind == KIND_MLSD && (flip_count == 0 || tie_count == 0)) begin
			err_count++;
			$display("%s: codes produced no flipped bit or no tie", row.name);
		end
		if (err_count == errs_before) begin
			$display("[PASS] %s (%0d frames, %0d flips, %0d ties)", row.name, row.frames,
				flip_count, tie_count);
		end else begin
			$display("[FAIL] %s with %0d errors", row.name, err_count - errs_before);
		end
	endtask

	initial begin
		rst_n_i     = 1'b0;
		codes_i     = '0;
		cfg_i       = '0;
		err_count   = 0;
		check_count = 0;
		void'($urandom(32'h04eb_9444));
		tests[0] = '{"reset_clear", make_cfg(1, 0, 0, 0, 0, 0, 0), 6, MODE_RAMP, KIND_RESET};
		tests[1] = '{"ffe_identity", make_cfg(1, 0, 0, 0, 0, 20, 0), 12, MODE_RAMP, KIND_EST};
		tests[2] = '{"ffe_cross_frame", make_cfg(3, -2, 5, 1, 5, 16, 4), 16, MODE_RANDOM,
			KIND_EST};
		tests[3] = '{"ffe_saturate", make_cfg(31, 30, 29, 1, 0, 10, 5), 8, MODE_EXTREME,
			KIND_SAT};
		tests[4] = '{"slice_no_isi", make_cfg(1, 0, 0, 0, 0, 40, 0), 12, MODE_RANDOM, KIND_BITS};
		tests[5] = '{"mlsd_random", make_cfg(2, -3, 1, 1, 0, 24, 12), 40, MODE_RANDOM_TIE,
			KIND_MLSD};
		for (int t = 0; t < 6; t++) begin
			run_test(tests[t]);
		end
		$display("%0d tests, %0d checks, %0d errors", 6, check_count, err_count);
		if (err_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Two cycles per frame plus the reset cycles of each test and some slack.
	initial begin
		longint limit_ns;
		#1;
		limit_ns = 400;
		for (int t = 0; t < 6; t++) begin
			limit_ns += (2 * tests[t].frames + 2) * 20;
		end
		#(limit_ns);
		$display("Timeout: the tests did not finish within %0d ns", limit_ns);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule : dsp_backend_tb

// File: project.f
logic/dsp_pkg.sv
logic/code_history.sv
logic/ffe_filter.sv
logic/bit_slicer.sv
logic/mlsd_checker.sv
logic/dsp_backend.sv
testbench/dsp_backend_properties.sv
testbench/dsp_backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= dsp_backend_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
